/* verilog/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    // Datapath and register file widths
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // RV32I major opcodes handled by this stage
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Decoded memory access kind
    typedef enum logic [3:0] {
        ACC_NONE,
        ACC_LB,
        ACC_LH,
        ACC_LW,
        ACC_LBU,
        ACC_LHU,
        ACC_SB,
        ACC_SH,
        ACC_SW
    } access_t;

    // Stage sequencing states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = mem_stage_pkg::word_t
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     en_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // Load on enable, otherwise hold for the later stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 valid_i,
    input  wire logic                 wb_ack_i,
    input  wire mem_stage_pkg::word_t inst_i,
    input  wire logic                 resp_i,
    output logic                      capture_o,
    output mem_stage_pkg::access_t    access_o,
    output logic                      req_o,
    output logic                      req_write_o,
    output logic                      busy_o,
    output logic                      done_o
);
    import mem_stage_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    access_t     access_d;
    logic [6:0]  opcode;
    logic [2:0]  funct3;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // Access kind from the incoming instruction word
    always_comb begin
        access_d = ACC_NONE;
        if (opcode == OPCODE_LOAD) begin
            case (funct3)
                3'b000:  access_d = ACC_LB;
                3'b001:  access_d = ACC_LH;
                3'b010:  access_d = ACC_LW;
                3'b100:  access_d = ACC_LBU;
                3'b101:  access_d = ACC_LHU;
                default: access_d = ACC_NONE;
            endcase
        end else if (opcode == OPCODE_STORE) begin
            case (funct3)
                3'b000:  access_d = ACC_SB;
                3'b001:  access_d = ACC_SH;
                3'b010:  access_d = ACC_SW;
                default: access_d = ACC_NONE;
            endcase
        end
    end

    // New instruction only taken while idle
    assign capture_o = (state_q == IDLE) && valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    state_d = (access_d == ACC_NONE) ? DONE : REQ;
                end
            end
            REQ: state_d = WAIT;
            WAIT: begin
                if (resp_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (wb_ack_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            access_o <= ACC_NONE;
        end else begin
            state_q <= state_d;
            if (capture_o) begin
                access_o <= access_d;
            end
        end
    end

    assign req_o       = (state_q == REQ);
    assign req_write_o = req_o && (access_o inside {ACC_SB, ACC_SH, ACC_SW});
    assign busy_o      = (state_q != IDLE);
    assign done_o      = (state_q == DONE);

    // The SRAM only answers a request we are waiting on
    resp_in_wait_a: assert property (@(posedge clk) disable iff (rst)
        resp_i |-> state_q == WAIT)
        else $error("mem_ctrl: SRAM response outside WAIT");

endmodule

`default_nettype wire

/* verilog/store_mask.sv */
`timescale 1ns/100ps
`default_nettype none

module store_mask (
    input  wire mem_stage_pkg::access_t access_i,
    input  wire mem_stage_pkg::word_t   addr_i,
    input  wire mem_stage_pkg::word_t   wdata_i,
    output logic [3:0]                  strb_o,
    output mem_stage_pkg::word_t        wdata_o
);
    import mem_stage_pkg::*;

    // Store data is replicated across lanes, the strobe picks the lane
    always_comb begin
        strb_o  = 4'b0000;
        wdata_o = '0;
        case (access_i)
            ACC_SB: begin
                strb_o  = 4'b0001 << addr_i[1:0];
                wdata_o = {4{wdata_i[7:0]}};
            end
            ACC_SH: begin
                strb_o  = addr_i[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{wdata_i[15:0]}};
            end
            ACC_SW: begin
                strb_o  = 4'b1111;
                wdata_o = wdata_i;
            end
            default: begin
                strb_o  = 4'b0000;
                wdata_o = '0;
            end
        endcase
    end

    // Halfword and word stores must be naturally aligned
    always_comb begin
        store_aligned_a: assert final (
            !(access_i == ACC_SH && addr_i[0]) &&
            !(access_i == ACC_SW && addr_i[1:0] != 2'b00))
            else $error("store_mask: misaligned store to %h", addr_i);
    end

endmodule

`default_nettype wire

/* verilog/load_align.sv */
`timescale 1ns/100ps
`default_nettype none

module load_align (
    input  wire mem_stage_pkg::access_t access_i,
    input  wire mem_stage_pkg::word_t   addr_i,
    input  wire mem_stage_pkg::word_t   rdata_i,
    output mem_stage_pkg::word_t        data_o
);
    import mem_stage_pkg::*;

    word_t shifted;

    // Move the addressed byte lane down to bit 0
    assign shifted = rdata_i >> {addr_i[1:0], 3'b000};

    always_comb begin
        case (access_i)
            ACC_LB: begin
                data_o = {{(DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            end
            ACC_LBU: begin
                data_o = {{(DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            end
            ACC_LH: begin
                data_o = {{(DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            end
            ACC_LHU: begin
                data_o = {{(DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            end
            ACC_LW: begin
                data_o = rdata_i;
            end
            // stores and non-memory ops return nothing
            default: begin
                data_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/data_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_sram #(
    parameter int SRAM_DEPTH   = 1024,
    parameter int SRAM_LATENCY = 1
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 req_i,
    input  wire logic                 write_i,
    input  wire mem_stage_pkg::word_t addr_i,
    input  wire logic [3:0]           strb_i,
    input  wire mem_stage_pkg::word_t wdata_i,
    output logic                      resp_o,
    output mem_stage_pkg::word_t      rdata_o
);
    import mem_stage_pkg::*;

    localparam int IDX_W = (SRAM_DEPTH > 1) ? $clog2(SRAM_DEPTH) : 1;
    localparam int CNT_W = $clog2(SRAM_LATENCY + 1);

    word_t            mem [SRAM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] cnt_q;

    // Word index, wrapping around the array
    assign idx = IDX_W'(addr_i[DATA_WIDTH-1:2] % SRAM_DEPTH);

    // Strobed byte writes, reads captured at the request edge
    always_ff @(posedge clk) begin
        if (req_i && write_i) begin
            for (int b = 0; b < DATA_WIDTH/8; b++) begin
                if (strb_i[b]) begin
                    mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        if (req_i && !write_i) begin
            rdata_o <= mem[idx];
        end
    end

    // Countdown from the request edge to the response cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (req_i) begin
            cnt_q <= CNT_W'(SRAM_LATENCY);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // One pulse, SRAM_LATENCY cycles after the request
    assign resp_o = (cnt_q == CNT_W'(1));

    no_overlap_a: assert property (@(posedge clk) disable iff (rst)
        req_i |-> cnt_q == '0)
        else $error("data_sram: request while another is outstanding");

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter int SRAM_DEPTH   = 1024,
    parameter int SRAM_LATENCY = 2
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      valid_i,
    input  wire mem_stage_pkg::word_t      pc_i,
    input  wire mem_stage_pkg::word_t      inst_i,
    input  wire mem_stage_pkg::word_t      result_i,
    input  wire mem_stage_pkg::word_t      dmem_addr_i,
    input  wire mem_stage_pkg::word_t      rs2_data_i,
    input  wire mem_stage_pkg::reg_addr_t  rd_addr_i,
    input  wire logic                      wb_ack_i,
    output logic                           busy_o,
    output logic                           done_o,
    output mem_stage_pkg::word_t           pc_o,
    output mem_stage_pkg::word_t           inst_o,
    output mem_stage_pkg::word_t           result_o,
    output mem_stage_pkg::word_t           rdata_o,
    output mem_stage_pkg::reg_addr_t       rd_addr_o
);
    import mem_stage_pkg::*;

    logic       capture;
    access_t    access;
    logic       sram_req;
    logic       sram_write;
    logic       sram_resp;
    word_t      sram_rdata;
    word_t      addr_q;
    word_t      rs2_q;
    logic [3:0] strb;
    word_t      store_data;

    mem_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .wb_ack_i   (wb_ack_i),
        .inst_i     (inst_i),
        .resp_i     (sram_resp),
        .capture_o  (capture),
        .access_o   (access),
        .req_o      (sram_req),
        .req_write_o(sram_write),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    // Pipeline registers, all loaded when an instruction is accepted
    stage_reg #(.payload_t(word_t)) u_pc_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(pc_i), .q_o(pc_o)
    );
    stage_reg #(.payload_t(word_t)) u_inst_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(inst_i), .q_o(inst_o)
    );
    stage_reg #(.payload_t(word_t)) u_result_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(result_i), .q_o(result_o)
    );
    stage_reg #(.payload_t(word_t)) u_addr_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(dmem_addr_i), .q_o(addr_q)
    );
    stage_reg #(.payload_t(word_t)) u_rs2_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(rs2_data_i), .q_o(rs2_q)
    );
    stage_reg #(.payload_t(reg_addr_t)) u_rd_reg (
        .clk(clk), .rst(rst), .en_i(capture), .d_i(rd_addr_i), .q_o(rd_addr_o)
    );

    store_mask u_store_mask (
        .access_i(access),
        .addr_i  (addr_q),
        .wdata_i (rs2_q),
        .strb_o  (strb),
        .wdata_o (store_data)
    );

    data_sram #(
        .SRAM_DEPTH  (SRAM_DEPTH),
        .SRAM_LATENCY(SRAM_LATENCY)
    ) u_sram (
        .clk    (clk),
        .rst    (rst),
        .req_i  (sram_req),
        .write_i(sram_write),
        .addr_i (addr_q),
        .strb_i (strb),
        .wdata_i(store_data),
        .resp_o (sram_resp),
        .rdata_o(sram_rdata)
    );

    load_align u_load_align (
        .access_i(access),
        .addr_i  (addr_q),
        .rdata_i (sram_rdata),
        .data_o  (rdata_o)
    );

    // Request to done takes exactly the SRAM latency spent in WAIT
    latency_a: assert property (@(posedge clk) disable iff (rst)
        u_ctrl.state_q == REQ |=>
            (u_ctrl.state_q == WAIT) [*SRAM_LATENCY] ##1 (u_ctrl.state_q == DONE))
        else $error("mem_stage: memory access latency mismatch");

    // Loads reach the SRAM only with a naturally aligned address
    load_aligned_a: assert property (@(posedge clk) disable iff (rst)
        (u_ctrl.state_q == REQ && !sram_write) |->
            !(access inside {ACC_LH, ACC_LHU} && addr_q[0]) &&
            !(access == ACC_LW && addr_q[1:0] != 2'b00))
        else $error("mem_stage: misaligned load from %h", addr_q);

endmodule

`default_nettype wire

/* bench/mem_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int          CLK_HALF  = 50;
    localparam int          TIMEOUT   = 40;
    localparam logic [31:0] SEED      = 32'hd856_505c;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk;
    logic      rst;
    logic      valid_i;
    word_t     pc_i;
    word_t     inst_i;
    word_t     result_i;
    word_t     dmem_addr_i;
    word_t     rs2_data_i;
    reg_addr_t rd_addr_i;
    logic      wb_ack_i;
    logic      busy_o;
    logic      done_o;
    word_t     pc_o;
    word_t     inst_o;
    word_t     result_o;
    word_t     rdata_o;
    reg_addr_t rd_addr_o;

    logic [7:0]  ref_mem [64];
    logic [31:0] lfsr_q;
    word_t       pc_count;
    int          errors;
    int          checks;
    int          tests;
    int          test_err_base;

    mem_stage #(.SRAM_DEPTH(16), .SRAM_LATENCY(3)) u_mem_stage (.*);

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic word_t encode(input logic store, input logic [2:0] f3, input reg_addr_t rd);
        if (store) begin
            return {7'd0, 5'd2, 5'd1, f3, 5'd0, OPCODE_STORE};
        end
        return {12'd0, 5'd1, f3, rd, OPCODE_LOAD};
    endfunction

    // Little-endian byte model, indexed modulo 16 words like the SRAM
    function automatic word_t ref_load(input logic [2:0] f3, input word_t addr);
        logic [5:0]  a;
        logic [15:0] half;
        a = addr[5:0];
        half = {ref_mem[a + 6'd1], ref_mem[a]};
        case (f3)
            3'b000: return {{24{ref_mem[a][7]}}, ref_mem[a]};
            3'b100: return {24'd0, ref_mem[a]};
            3'b001: return {{16{half[15]}}, half};
            3'b101: return {16'd0, half};
            default: return {ref_mem[a + 6'd3], ref_mem[a + 6'd2], half};
        endcase
    endfunction

    task automatic ref_store(input logic [2:0] f3, input word_t addr, input word_t data);
        int nbytes;
        nbytes = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[addr[5:0] + 6'(i)] = data[i*8 +: 8];
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $finish;
    endtask

    task automatic wait_idle();
        for (int n = 0; busy_o && n < TIMEOUT; n++) @(negedge clk);
        if (busy_o) abort_run("Stage never went idle, busy_o stuck high");
    endtask

    task automatic wait_done();
        for (int n = 0; !done_o && n < TIMEOUT; n++) @(negedge clk);
        if (!done_o) abort_run("Timed out waiting for done_o");
    endtask

    task automatic send(input word_t pc, input word_t inst, input word_t res,
                        input word_t addr, input word_t data, input reg_addr_t rd);
        wait_idle();
        @(negedge clk);
        valid_i     = 1'b1;
        pc_i        = pc;
        inst_i      = inst;
        result_i    = res;
        dmem_addr_i = addr;
        rs2_data_i  = data;
        rd_addr_i   = rd;
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    task automatic ack_result();
        wb_ack_i = 1'b1;
        @(negedge clk);
        wb_ack_i = 1'b0;
    endtask

    // One load or store, checked against the byte model
    task automatic run_access(input logic store, input logic [2:0] f3,
                              input word_t addr, input word_t data);
        word_t     inst;
        word_t     res;
        word_t     exp;
        word_t     pc;
        reg_addr_t rd;
        rd = reg_addr_t'(random_bits(5));
        res = random_bits(32);
        pc = pc_count;
        pc_count += 4;
        inst = encode(store, f3, rd);
        exp = store ? '0 : ref_load(f3, addr);
        if (store) ref_store(f3, addr, data);
        send(pc, inst, res, addr, data, rd);
        wait_done();
        check_word(pc_o, pc, "pc_o");
        check_word(inst_o, inst, "inst_o");
        check_word(result_o, res, "result_o");
        check_word(word_t'(rd_addr_o), word_t'(rd), "rd_addr_o");
        check_word(rdata_o, exp, $sformatf("rdata_o at %h", addr));
        ack_result();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic test_reset();
        check_word(word_t'(done_o), '0, "done_o after reset");
        check_word(word_t'(busy_o), '0, "busy_o after reset");
        check_word(pc_o | inst_o | result_o | rdata_o, '0, "outputs after reset");
        check_word(word_t'(rd_addr_o), '0, "rd_addr_o after reset");
    endtask

    task automatic test_word_rw();
        for (int w = 0; w < 16; w++) begin
            run_access(1'b1, 3'b010, 32'h100 + 4 * w, random_bits(32));
            run_access(1'b0, 3'b010, 32'h100 + 4 * w, '0);
        end
    endtask

    task automatic test_sub_stores();
        for (int off = 0; off < 4; off++) begin
            run_access(1'b1, 3'b000, 32'h120 + off, random_bits(32));
            run_access(1'b0, 3'b010, 32'h120, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_access(1'b1, 3'b001, 32'h124 + off, random_bits(32));
            run_access(1'b0, 3'b010, 32'h124, '0);
        end
    endtask

    task automatic test_sub_loads();
        // Bytes and halfwords of both signs
        run_access(1'b1, 3'b010, 32'h130, 32'h25c3_7f81);
        run_access(1'b1, 3'b010, 32'h134, 32'h8a5e_f00d);
        for (int base = 32'h130; base <= 32'h134; base += 4) begin
            for (int off = 0; off < 4; off++) begin
                run_access(1'b0, 3'b000, base + off, '0);
                run_access(1'b0, 3'b100, base + off, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                run_access(1'b0, 3'b001, base + off, '0);
                run_access(1'b0, 3'b101, base + off, '0);
            end
        end
    endtask

    task automatic test_stall();
        word_t pc;
        word_t res;
        word_t inst;
        pc = pc_count;
        pc_count += 4;
        res = random_bits(32);
        inst = {12'h123, 5'd3, 3'b000, 5'd9, 7'b0110011};
        send(pc, inst, res, 32'h104, 32'hffff_ffff, 5'd9);
        wait_done();
        for (int i = 0; i < 6; i++) begin
            // A store offered mid-stall must not be taken
            valid_i = (i == 2);
            inst_i = encode(1'b1, 3'b010, 5'd0);
            dmem_addr_i = 32'h104;
            rs2_data_i = 32'hdead_beef;
            check_word(word_t'({done_o, busy_o}), 32'd3, "done_o and busy_o while stalled");
            check_word(pc_o, pc, "pc_o while stalled");
            check_word(inst_o, inst, "inst_o while stalled");
            check_word(result_o, res, "result_o while stalled");
            check_word(word_t'(rd_addr_o), 32'd9, "rd_addr_o while stalled");
            check_word(rdata_o, '0, "rdata_o for non-memory op");
            @(negedge clk);
        end
        valid_i = 1'b0;
        ack_result();
        check_word(word_t'({done_o, busy_o}), '0, "done_o and busy_o after ack");
        run_access(1'b0, 3'b010, 32'h104, '0);
    endtask

    task automatic test_random();
        logic [2:0] kind;
        logic [2:0] f3;
        word_t      addr;
        for (int i = 0; i < 50; i++) begin
            kind = 3'(random_bits(3));
            f3 = (kind < 5) ? ((kind < 3) ? kind : kind + 3'd1) : kind - 3'd5;
            addr = random_bits(32);
            if (f3[1:0] == 2'b01) addr[0] = 1'b0;
            if (f3[1:0] == 2'b10) addr[1:0] = 2'b00;
            run_access(kind >= 5, f3, addr, random_bits(32));
        end
    endtask

    initial begin
        lfsr_q = SEED;
        pc_count = 32'h0000_1000;
        errors = 0;
        checks = 0;
        tests = 0;
        test_err_base = 0;
        rst = 1'b1;
        valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        result_i = '0;
        dmem_addr_i = '0;
        rs2_data_i = '0;
        rd_addr_i = '0;
        wb_ack_i = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        end_test("reset state");
        test_word_rw();
        end_test("word store and load");
        test_sub_stores();
        end_test("byte and halfword stores");
        test_sub_loads();
        end_test("sign and zero extension");
        test_stall();
        end_test("pass-through and stall");
        test_random();
        end_test("random accesses");
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_stage.f */
verilog/mem_stage_pkg.sv
verilog/stage_reg.sv
verilog/mem_ctrl.sv
verilog/store_mask.sv
verilog/load_align.sv
verilog/data_sram.sv
verilog/mem_stage.sv
bench/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - verilog/mem_stage_pkg.sv
  - verilog/stage_reg.sv
  - verilog/mem_ctrl.sv
  - verilog/store_mask.sv
  - verilog/load_align.sv
  - verilog/data_sram.sv
  - verilog/mem_stage.sv
  - target: test
    files:
      - bench/mem_stage_tb.sv
